// File: sources.f
logic/rv_inst_pkg.sv
logic/ld_decd_pkg.sv
logic/ld_decd_if.sv
logic/ld_std_decd.sv
logic/ld_ext_decd.sv
logic/ld_decd_stage.sv
logic/ld_offset_stage.sv
logic/ld_decd_top.sv
verif/ld_decd_asserts.sv
verif/ld_decd_tb.sv

// File: Bender.yml
package:
  name: ld_decd

sources:
  - logic/rv_inst_pkg.sv
  - logic/ld_decd_pkg.sv
  - logic/ld_decd_if.sv
  - logic/ld_std_decd.sv
  - logic/ld_ext_decd.sv
  - logic/ld_decd_stage.sv
  - logic/ld_offset_stage.sv
  - logic/ld_decd_top.sv
  - target: simulation
    files:
      - verif/ld_decd_asserts.sv
      - verif/ld_decd_tb.sv

// File: verif/ld_decd_tb.sv
//====================================================================
// load decoder testbench
// directed tests against a reference model of the decode rules
//====================================================================
`timescale 1ns/1ps

module ld_decd_tb import rv_inst_pkg::*, ld_decd_pkg::*; ();

  localparam int LATENCY    = 2;    // input sample edge to output edge
  localparam int WAIT_LIMIT = 20;   // cycles to drain the pipe

  typedef struct packed {
    logic                     illegal;
    logic                     atomic;
    logic                     sign_extend;
    logic [1:0]               inst_type;
    logic [1:0]               inst_size;
    logic                     fls;
    logic                     ldr;
    logic                     off_0_extend;
    logic                     lsfifo;
    logic [OFFSET_W-1:0]      offset;
    logic [OFFSET_PLUS_W-1:0] offset_plus;
    logic [SHIFT_W-1:0]       shift;
  } ld_fields_t;

  logic                     forever_cpuclk;
  logic                     arst_n;
  logic                     inst_vld;
  logic [INST_W-1:0]        inst;
  logic                     decd_vld;
  logic                     decd_illegal;
  logic                     atomic;
  logic                     sign_extend;
  ld_type_e                 inst_type;
  ld_size_e                 inst_size;
  logic                     fls;
  logic                     ldr;
  logic                     off_0_extend;
  logic                     lsfifo;
  logic [OFFSET_W-1:0]      offset;
  logic [OFFSET_PLUS_W-1:0] offset_plus;
  logic [SHIFT_W-1:0]       shift;

  int                seed = 22603;
  int                err_count = 0;
  int                n_checks = 0;
  int                neg_count = 0;   // falling edges seen
  logic [INST_W-1:0] word_q[$];       // words in flight
  int                due_q[$];        // falling edge where each result is due

  initial
  begin
    forever_cpuclk = 1'b0;
    forever #50 forever_cpuclk = ~forever_cpuclk;
  end

  initial
  begin
    #1000000;
    $display("simulation ran past its time limit");
    $display("TEST FAIL");
    $finish;
  end

  ld_decd_top u_ld_decd_top (.*);

  bind ld_decd_top ld_decd_asserts u_ld_decd_asserts (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .decd_vld       (decd_vld),
    .decd_illegal   (decd_illegal),
    .ldr            (ldr),
    .offset         (offset),
    .shift          (shift)
  );

  //====================================================================
  // reference model
  //====================================================================
  function automatic logic amo_op_ok(logic [4:0] f5);
    // swap add xor and or min max minu maxu
    case (f5)
      5'b00001, 5'b00000, 5'b00100, 5'b01100, 5'b01000,
      5'b10000, 5'b10100, 5'b11000, 5'b11100: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic ld_fields_t expect_fields(logic [INST_W-1:0] w);
    ld_fields_t e;
    logic [2:0] f3;
    logic [2:0] cf3;
    logic [4:0] f5;
    logic       is_lr;
    logic       hit;
    e     = '0;
    f3    = w[14:12];
    cf3   = w[15:13];
    f5    = w[31:27];
    is_lr = (f5 == 5'b00010) && (w[24:20] == 5'd0);
    hit   = 1'b0;
    if (w[1:0] == 2'b11)
    begin
      if (w[6:0] == LOAD && f3 != 3'b111)
      begin
        hit           = 1'b1;
        e.inst_size   = f3[1:0];
        e.sign_extend = (f3 <= 3'b010);   // lb lh lw
        e.lsfifo      = 1'b1;
        e.offset      = w[31:20];
      end
      else if (w[6:0] == LOAD_FP && f3 >= 3'b001 && f3 <= 3'b011)
      begin
        hit         = 1'b1;
        e.inst_size = f3[1:0];
        e.fls       = 1'b1;
        e.lsfifo    = 1'b1;
        e.offset    = w[31:20];
      end
      else if (w[6:0] == AMO && (f3 == 3'b010 || f3 == 3'b011) && (is_lr || amo_op_ok(f5)))
      begin
        hit           = 1'b1;
        e.atomic      = 1'b1;
        e.inst_type   = is_lr ? RESERVE : NORMAL;
        e.sign_extend = (f3 == 3'b010);
        e.inst_size   = (f3 == 3'b010) ? WORD : DWORD;
      end
      else if (w[6:0] == CUSTOM0 && !f5[0] &&
               ((f3 == 3'b100 && !(f5[4] && f5[3:2] == 2'b11)) ||
                (f3 == 3'b110 && !f5[4] && f5[3])))
      begin
        // funct5 is {unsigned, size, lur, 0}
        hit            = 1'b1;
        e.ldr          = 1'b1;
        e.inst_size    = f5[3:2];
        e.sign_extend  = !f5[4] && f5[3:2] != 2'b11;
        e.fls          = (f3 == 3'b110);
        e.off_0_extend = f5[1];
        e.lsfifo       = 1'b1;
      end
    end
    else if ((w[1:0] == 2'b00 || w[1:0] == 2'b10) && cf3 >= 3'b001 && cf3 <= 3'b011)
    begin
      hit           = 1'b1;
      e.sign_extend = (cf3 == 3'b010);
      e.inst_size   = (cf3 == 3'b010) ? WORD : DWORD;
      e.fls         = (cf3 == 3'b001);
      e.lsfifo      = (w[1:0] == 2'b00);
      if (w[1:0] == 2'b00 && cf3 == 3'b010)
      begin
        e.offset[5:3] = w[12:10];   // c.lw
        e.offset[2]   = w[6];
        e.offset[6]   = w[5];
      end
      else if (w[1:0] == 2'b00)
      begin
        e.offset[5:3] = w[12:10];   // c.ld c.fld
        e.offset[7:6] = w[6:5];
      end
      else if (cf3 == 3'b010)
      begin
        e.offset[5]   = w[12];      // c.lwsp
        e.offset[4:2] = w[6:4];
        e.offset[7:6] = w[3:2];
      end
      else
      begin
        e.offset[5]   = w[12];      // c.ldsp c.fldsp
        e.offset[4:3] = w[6:5];
        e.offset[8:6] = w[4:2];
      end
    end
    if (!hit)
    begin
      e         = '0;
      e.illegal = 1'b1;
    end
    else
    begin
      // signed offset plus 16, kept to 13 bits
      e.offset_plus = OFFSET_PLUS_W'(int'($signed(e.offset)) + OFFSET_INC);
      e.shift       = '0;
      e.shift[e.ldr ? w[26:25] : 2'd0] = 1'b1;
    end
    return e;
  endfunction

  //====================================================================
  // checking helpers
  //====================================================================
  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    n_checks++;
    assert (got === exp)
    else
    begin
      $display("** Error @%0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic compare_result(logic [INST_W-1:0] w);
    ld_fields_t e;
    e = expect_fields(w);
    check_val("decd_illegal", decd_illegal, e.illegal);
    check_val("atomic", atomic, e.atomic);
    check_val("sign_extend", sign_extend, e.sign_extend);
    check_val("inst_type", inst_type, e.inst_type);
    check_val("inst_size", inst_size, e.inst_size);
    check_val("fls", fls, e.fls);
    check_val("ldr", ldr, e.ldr);
    check_val("off_0_extend", off_0_extend, e.off_0_extend);
    check_val("lsfifo", lsfifo, e.lsfifo);
    check_val("offset", offset, e.offset);
    check_val("offset_plus", offset_plus, e.offset_plus);
    check_val("shift", shift, e.shift);
  endtask

  // outputs sampled on the falling edge, away from the drive edge
  always @(negedge forever_cpuclk)
  begin
    neg_count++;
    if (arst_n)
    begin
      if (due_q.size() != 0 && due_q[0] == neg_count)
      begin
        assert (decd_vld)
        else
        begin
          $display("** Error @%0t: decd_vld = %b, expected 1 for word 0x%h",
                   $time, decd_vld, word_q[0]);
          err_count++;
        end
        compare_result(word_q.pop_front());
        void'(due_q.pop_front());
      end
      else
      begin
        assert (!decd_vld)
        else
        begin
          $display("** Error @%0t: decd_vld = %b, expected 0", $time, decd_vld);
          err_count++;
        end
      end
    end
  end

  task automatic send_word(logic [INST_W-1:0] w);
    @(posedge forever_cpuclk);
    inst     <= w;
    inst_vld <= 1'b1;
    word_q.push_back(w);
    due_q.push_back(neg_count + 1 + LATENCY);
  endtask

  task automatic drain_results();
    int i;
    @(posedge forever_cpuclk);
    inst_vld <= 1'b0;
    for (i = 0; i < WAIT_LIMIT && due_q.size() != 0; i++)
    begin
      @(posedge forever_cpuclk);
    end
    if (due_q.size() != 0)
    begin
      $display("timeout, %0d results never came out of the pipe", due_q.size());
      err_count++;
      word_q.delete();
      due_q.delete();
    end
  endtask

  task automatic report_test(string name, int err0);
    $display("%s finished with %0d errors", name, err_count - err0);
  endtask

  //====================================================================
  // tests
  //====================================================================
  task automatic test_base_loads();
    int          err0;
    int          i;
    int          j;
    logic [31:0] r;
    err0 = err_count;
    for (i = 0; i < 7; i++)
    begin
      for (j = 0; j < 4; j++)
      begin
        r = $random(seed);
        send_word({r[31:15], i[2:0], r[11:7], LOAD});
      end
    end
    for (i = 1; i <= 3; i++)
    begin
      for (j = 0; j < 4; j++)
      begin
        r = $random(seed);
        send_word({r[31:15], i[2:0], r[11:7], LOAD_FP});
      end
    end
    drain_results();
    report_test("base and float loads", err0);
  endtask

  task automatic test_atomics();
    int          err0;
    int          i;
    int          k;
    logic [31:0] r;
    logic [4:0]  f5_list [10] = '{5'b00010, 5'b00000, 5'b00001, 5'b00100, 5'b01000,
                                  5'b01100, 5'b10000, 5'b10100, 5'b11000, 5'b11100};
    err0 = err_count;
    for (i = 2; i <= 3; i++)
    begin
      for (k = 0; k < 10; k++)
      begin
        r = $random(seed);
        send_word({f5_list[k], r[26:25], (k == 0) ? 5'd0 : r[24:20], r[19:15],
                   i[2:0], r[11:7], AMO});   // k 0 is lr, rs2 x0
      end
    end
    drain_results();
    report_test("atomics", err0);
  endtask

  task automatic test_compressed();
    int          err0;
    int          q;
    int          i;
    int          j;
    logic [31:0] r;
    err0 = err_count;
    for (q = 0; q < 2; q++)
    begin
      for (i = 1; i <= 3; i++)
      begin
        for (j = 0; j < 4; j++)
        begin
          r = $random(seed);
          send_word({r[31:16], i[2:0], r[12:2], q[0], 1'b0});   // quadrant 0 or 2
        end
      end
    end
    drain_results();
    report_test("compressed loads", err0);
  endtask

  task automatic test_indexed();
    int          err0;
    int          fp;
    int          uns;
    int          sz;
    int          lur;
    logic [31:0] r;
    err0 = err_count;
    for (fp = 0; fp < 2; fp++)
    begin
      for (uns = 0; uns < 2; uns++)
      begin
        for (sz = 0; sz < 4; sz++)
        begin
          for (lur = 0; lur < 2; lur++)
          begin
            // no unsigned dword, flr has only word and dword
            if (!(fp == 0 && uns == 1 && sz == 3) && !(fp == 1 && (uns == 1 || sz < 2)))
            begin
              r = $random(seed);
              send_word({uns[0], sz[1:0], lur[0], 1'b0, r[26:15],
                         fp[0] ? 3'b110 : 3'b100, r[11:7], CUSTOM0});
            end
          end
        end
      end
    end
    drain_results();
    report_test("indexed loads", err0);
  endtask

  task automatic test_stream_mixed();
    int          err0;
    int          i;
    int          k;
    logic [31:0] r;
    logic [31:0] w;
    err0 = err_count;
    @(negedge forever_cpuclk);   // state left by reset
    check_val("decd_vld", decd_vld, 0);
    check_val("decd_illegal", decd_illegal, 0);
    check_val("offset", offset, 0);
    check_val("offset_plus", offset_plus, 0);
    check_val("shift", shift, 0);
    check_val("flags", {atomic, sign_extend, fls, ldr, off_0_extend, lsfifo}, 0);
    check_val("inst_type", inst_type, 0);
    check_val("inst_size", inst_size, 0);
    for (i = 0; i < 40; i++)
    begin
      r = $random(seed);
      k = $unsigned($random(seed)) % 6;
      case (k)
        0:       w = {r[31:7], LOAD};
        1:       w = {r[31:7], AMO};       // sc and stray funct5 are illegal
        2:       w = {r[31:2], r[1], 1'b0};
        3:       w = {r[31:7], CUSTOM0};
        4:       w = r;
        default: w = {r[31:7], 7'b0110011};   // OP major, never a load
      endcase
      send_word(w);
    end
    drain_results();
    report_test("mixed stream", err0);
  endtask

  initial
  begin
    inst     = '0;
    inst_vld = 1'b0;
    arst_n   = 1'b0;
    repeat (16) @(posedge forever_cpuclk);
    arst_n <= 1'b1;
    test_stream_mixed();
    test_base_loads();
    test_atomics();
    test_compressed();
    test_indexed();
    $display("tests 5, checks %0d, errors %0d", n_checks, err_count);
    if (err_count == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: verif/ld_decd_asserts.sv
//====================================================================
// load decoder pipeline assertions, bound to the top level
//====================================================================
`timescale 1ns/1ps

module ld_decd_asserts import ld_decd_pkg::*; (
  input logic                forever_cpuclk,
  input logic                arst_n,
  input logic                decd_vld,
  input logic                decd_illegal,
  input logic                ldr,
  input logic [OFFSET_W-1:0] offset,
  input logic [SHIFT_W-1:0]  shift
);

  vld_low_in_reset: assert property (
    @(posedge forever_cpuclk) !arst_n |-> !decd_vld
  ) else $error("decd_vld high while reset is asserted");

  // illegal words carry an all zero shift
  shift_onehot: assert property (
    @(posedge forever_cpuclk) disable iff (!arst_n)
    (decd_vld && !decd_illegal) |-> $onehot(shift)
  ) else $error("shift not one-hot on a decoded load");

  ldr_zero_offset: assert property (
    @(posedge forever_cpuclk) disable iff (!arst_n)
    ldr |-> (offset == '0)
  ) else $error("indexed load with a nonzero offset");

endmodule

// File: logic/ld_decd_top.sv
//====================================================================
// two-stage registered load decoder for the load/store issue pipe
//====================================================================
`timescale 1ns/1ps

module ld_decd_top import rv_inst_pkg::*, ld_decd_pkg::*; (
  input  logic                     forever_cpuclk,
  input  logic                     arst_n,
  input  logic                     inst_vld,
  input  logic [INST_W-1:0]        inst,
  output logic                     decd_vld,
  output logic                     decd_illegal,
  output logic                     atomic,
  output logic                     sign_extend,
  output ld_type_e                 inst_type,
  output ld_size_e                 inst_size,
  output logic                     fls,
  output logic                     ldr,
  output logic                     off_0_extend,
  output logic                     lsfifo,
  output logic [OFFSET_W-1:0]      offset,
  output logic [OFFSET_PLUS_W-1:0] offset_plus,
  output logic [SHIFT_W-1:0]       shift
);

  ld_decd_if u_decd_if ();   // stage 1 to stage 2

  ld_decd_stage u_ld_decd_stage (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .inst_vld       (inst_vld),
    .inst           (inst),
    .decd           (u_decd_if.producer)
  );

  ld_offset_stage u_ld_offset_stage (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .decd           (u_decd_if.consumer),
    .decd_vld       (decd_vld),
    .decd_illegal   (decd_illegal),
    .atomic         (atomic),
    .sign_extend    (sign_extend),
    .inst_type      (inst_type),
    .inst_size      (inst_size),
    .fls            (fls),
    .ldr            (ldr),
    .off_0_extend   (off_0_extend),
    .lsfifo         (lsfifo),
    .offset         (offset),
    .offset_plus    (offset_plus),
    .shift          (shift)
  );

endmodule

// File: logic/ld_offset_stage.sv
//====================================================================
// load decode, second pipe stage
// builds offset, offset plus 16 and index shift, registers the outputs
//====================================================================
`timescale 1ns/1ps

module ld_offset_stage import ld_decd_pkg::*; (
  input  logic                     forever_cpuclk,
  input  logic                     arst_n,
  ld_decd_if.consumer              decd,
  output logic                     decd_vld,
  output logic                     decd_illegal,
  output logic                     atomic,
  output logic                     sign_extend,
  output ld_type_e                 inst_type,
  output ld_size_e                 inst_size,
  output logic                     fls,
  output logic                     ldr,
  output logic                     off_0_extend,
  output logic                     lsfifo,
  output logic [OFFSET_W-1:0]      offset,
  output logic [OFFSET_PLUS_W-1:0] offset_plus,
  output logic [SHIFT_W-1:0]       shift
);

  logic                     nxt_ldr;
  logic [OFFSET_W-1:0]      nxt_offset;
  logic [OFFSET_PLUS_W-1:0] nxt_offset_plus;
  logic [SHIFT_W-1:0]       nxt_shift;

  assign nxt_ldr = (decd.off_fmt == OFF_INDEX);

  //====================================================================
  // offset assembly from the scattered immediate bits
  //====================================================================
  always_comb
  begin
    case (decd.off_fmt)
      OFF_ITYPE: nxt_offset = decd.inst[31:20];
      OFF_CL_W:  nxt_offset = {5'b0, decd.inst[5], decd.inst[12:10], decd.inst[6], 2'b0};
      OFF_CL_D:  nxt_offset = {4'b0, decd.inst[6:5], decd.inst[12:10], 3'b0};
      OFF_CI_W:  nxt_offset = {4'b0, decd.inst[3:2], decd.inst[12], decd.inst[6:4], 2'b0};
      OFF_CI_D:  nxt_offset = {3'b0, decd.inst[4:2], decd.inst[12], decd.inst[6:5], 3'b0};
      default:   nxt_offset = '0;   // atomic, indexed, undecoded
    endcase
  end

  always_comb
  begin
    if (decd.illegal)
    begin
      nxt_offset_plus = '0;
      nxt_shift       = '0;
    end
    else
    begin
      // sign-extended offset plus 16, wraps at 13 bits
      nxt_offset_plus = {nxt_offset[OFFSET_W-1], nxt_offset} + OFFSET_PLUS_W'(OFFSET_INC);
      nxt_shift       = nxt_ldr ? (SHIFT_W'(1) << decd.inst[26:25]) : SHIFT_W'(1);
    end
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      decd_vld     <= 1'b0;
      decd_illegal <= 1'b0;
      atomic       <= 1'b0;
      sign_extend  <= 1'b0;
      inst_type    <= NORMAL;
      inst_size    <= BYTE;
      fls          <= 1'b0;
      ldr          <= 1'b0;
      off_0_extend <= 1'b0;
      lsfifo       <= 1'b0;
      offset       <= '0;
      offset_plus  <= '0;
      shift        <= '0;
    end
    else
    begin
      decd_vld     <= decd.vld;
      decd_illegal <= decd.vld & decd.illegal;   // only flagged on a valid word
      atomic       <= decd.atomic;
      sign_extend  <= decd.sign_extend;
      inst_type    <= decd.inst_type;
      inst_size    <= decd.inst_size;
      fls          <= decd.fls;
      ldr          <= nxt_ldr;
      off_0_extend <= decd.off_0_extend;
      lsfifo       <= decd.lsfifo;
      offset       <= nxt_offset;
      offset_plus  <= nxt_offset_plus;
      shift        <= nxt_shift;
    end
  end

endmodule

// File: logic/ld_decd_stage.sv
//====================================================================
// load decode, first pipe stage
// merges the two decoders and registers the fields with the word
//====================================================================
`timescale 1ns/1ps

module ld_decd_stage import rv_inst_pkg::*, ld_decd_pkg::*; (
  input  logic              forever_cpuclk,
  input  logic              arst_n,
  input  logic              inst_vld,
  input  logic [INST_W-1:0] inst,
  ld_decd_if.producer       decd
);

  logic     std_hit;
  off_fmt_e std_off_fmt;
  logic     std_sign_extend;
  ld_size_e std_inst_size;
  logic     std_fls;
  logic     std_lsfifo;

  logic     ext_hit;
  off_fmt_e ext_off_fmt;
  logic     ext_atomic;
  ld_type_e ext_inst_type;
  logic     ext_sign_extend;
  ld_size_e ext_inst_size;
  logic     ext_fls;
  logic     ext_off_0_extend;
  logic     ext_lsfifo;

  ld_std_decd u_ld_std_decd (
    .inst        (inst),
    .hit         (std_hit),
    .off_fmt     (std_off_fmt),
    .sign_extend (std_sign_extend),
    .inst_size   (std_inst_size),
    .fls         (std_fls),
    .lsfifo      (std_lsfifo)
  );

  ld_ext_decd u_ld_ext_decd (
    .inst         (inst),
    .hit          (ext_hit),
    .off_fmt      (ext_off_fmt),
    .atomic       (ext_atomic),
    .inst_type    (ext_inst_type),
    .sign_extend  (ext_sign_extend),
    .inst_size    (ext_inst_size),
    .fls          (ext_fls),
    .off_0_extend (ext_off_0_extend),
    .lsfifo       (ext_lsfifo)
  );

  //====================================================================
  // decoder select, disjoint opcode spaces
  //====================================================================
  off_fmt_e nxt_off_fmt;
  logic     nxt_atomic;
  ld_type_e nxt_inst_type;
  logic     nxt_sign_extend;
  ld_size_e nxt_inst_size;
  logic     nxt_fls;
  logic     nxt_off_0_extend;
  logic     nxt_lsfifo;

  always_comb
  begin
    // all zero when nothing matched
    nxt_off_fmt      = OFF_ZERO;
    nxt_atomic       = 1'b0;
    nxt_inst_type    = NORMAL;
    nxt_sign_extend  = 1'b0;
    nxt_inst_size    = BYTE;
    nxt_fls          = 1'b0;
    nxt_off_0_extend = 1'b0;
    nxt_lsfifo       = 1'b0;
    if (std_hit)
    begin
      nxt_off_fmt     = std_off_fmt;
      nxt_sign_extend = std_sign_extend;
      nxt_inst_size   = std_inst_size;
      nxt_fls         = std_fls;
      nxt_lsfifo      = std_lsfifo;
    end
    else if (ext_hit)
    begin
      nxt_off_fmt      = ext_off_fmt;
      nxt_atomic       = ext_atomic;
      nxt_inst_type    = ext_inst_type;
      nxt_sign_extend  = ext_sign_extend;
      nxt_inst_size    = ext_inst_size;
      nxt_fls          = ext_fls;
      nxt_off_0_extend = ext_off_0_extend;
      nxt_lsfifo       = ext_lsfifo;
    end
  end

  //====================================================================
  // stage register
  //====================================================================
  always_ff @(posedge forever_cpuclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      decd.vld          <= 1'b0;
      decd.illegal      <= 1'b0;
      decd.inst         <= '0;
      decd.off_fmt      <= OFF_ZERO;
      decd.atomic       <= 1'b0;
      decd.inst_type    <= NORMAL;
      decd.sign_extend  <= 1'b0;
      decd.inst_size    <= BYTE;
      decd.fls          <= 1'b0;
      decd.off_0_extend <= 1'b0;
      decd.lsfifo       <= 1'b0;
    end
    else
    begin
      decd.vld          <= inst_vld;              // plain level, no handshake
      decd.illegal      <= ~(std_hit | ext_hit);
      decd.inst         <= inst;
      decd.off_fmt      <= nxt_off_fmt;
      decd.atomic       <= nxt_atomic;
      decd.inst_type    <= nxt_inst_type;
      decd.sign_extend  <= nxt_sign_extend;
      decd.inst_size    <= nxt_inst_size;
      decd.fls          <= nxt_fls;
      decd.off_0_extend <= nxt_off_0_extend;
      decd.lsfifo       <= nxt_lsfifo;
    end
  end

endmodule

// File: logic/ld_ext_decd.sv
//====================================================================
// atomic and register-indexed load decoder
// combinational, covers lr, amo and the custom0 indexed loads
//====================================================================
`timescale 1ns/1ps

module ld_ext_decd import rv_inst_pkg::*, ld_decd_pkg::*; (
  input  logic [INST_W-1:0] inst,
  output logic              hit,
  output off_fmt_e          off_fmt,
  output logic              atomic,
  output ld_type_e          inst_type,
  output logic              sign_extend,
  output ld_size_e          inst_size,
  output logic              fls,
  output logic              off_0_extend,
  output logic              lsfifo
);

  logic [FUNCT3_W-1:0] funct3;
  logic [4:0]          funct5;
  logic                lr_op;
  logic                amo_op;
  logic                idx_vld;

  assign funct3 = inst[14:12];
  assign funct5 = inst[31:27];
  assign lr_op  = (funct5 == FUNCT5_LR) && (inst[24:20] == 5'b0);   // rs2 must be x0

  // the nine amo ops, sc excluded
  always_comb
  begin
    case (funct5)
      5'b00000, 5'b00001, 5'b00100, 5'b01000, 5'b01100,
      5'b10000, 5'b10100, 5'b11000, 5'b11100: amo_op = 1'b1;
      default:                                amo_op = 1'b0;
    endcase
  end

  // indexed funct5 reads as {unsigned, size, lur, 0}
  always_comb
  begin
    idx_vld = 1'b0;
    if (!funct5[0])
    begin
      if (funct3 == F3_IDX_INT)
      begin
        idx_vld = ~(funct5[4] & (funct5[3:2] == 2'b11));   // no unsigned dword
      end
      else if (funct3 == F3_IDX_FP)
      begin
        idx_vld = ~funct5[4] & funct5[3];   // word and dword only
      end
    end
  end

  always_comb
  begin
    hit          = 1'b0;
    off_fmt      = OFF_ZERO;
    atomic       = 1'b0;
    inst_type    = NORMAL;
    sign_extend  = 1'b0;
    inst_size    = BYTE;
    fls          = 1'b0;
    off_0_extend = 1'b0;
    lsfifo       = 1'b0;
    case (inst[6:0])
      AMO:
      begin
        if ((funct3 == F3_AMO_W || funct3 == F3_AMO_D) && (lr_op || amo_op))
        begin
          hit         = 1'b1;
          atomic      = 1'b1;    // no offset, stays out of the fifo
          inst_type   = lr_op ? RESERVE : NORMAL;
          sign_extend = (funct3 == F3_AMO_W);
          inst_size   = (funct3 == F3_AMO_W) ? WORD : DWORD;
        end
      end
      CUSTOM0:
      begin
        if (idx_vld)
        begin
          hit          = 1'b1;
          off_fmt      = OFF_INDEX;
          sign_extend  = ~funct5[4] & (funct5[3:2] != 2'b11);
          inst_size    = ld_size_e'(funct5[3:2]);
          fls          = (funct3 == F3_IDX_FP);
          off_0_extend = funct5[1];   // lur forms
          lsfifo       = 1'b1;
        end
      end
      default:
      begin
        hit = 1'b0;
      end
    endcase
  end

endmodule

// File: logic/ld_std_decd.sv
//====================================================================
// base, float and compressed load decoder
// combinational, flags a hit and returns the control fields
//====================================================================
`timescale 1ns/1ps

module ld_std_decd import rv_inst_pkg::*, ld_decd_pkg::*; (
  input  logic [INST_W-1:0] inst,
  output logic              hit,
  output off_fmt_e          off_fmt,
  output logic              sign_extend,
  output ld_size_e          inst_size,
  output logic              fls,
  output logic              lsfifo
);

  logic [FUNCT3_W-1:0] funct3;     // 32-bit form
  logic [FUNCT3_W-1:0] c_funct3;   // compressed form
  logic [1:0]          c_quad;

  assign funct3   = inst[14:12];
  assign c_funct3 = inst[15:13];
  assign c_quad   = inst[1:0];

  always_comb
  begin
    hit         = 1'b0;
    off_fmt     = OFF_ZERO;
    sign_extend = 1'b0;
    inst_size   = BYTE;
    fls         = 1'b0;
    lsfifo      = 1'b0;
    if (c_quad == 2'b11)
    begin
      case (inst[6:0])
        LOAD:
        begin
          if (funct3 != 3'b111)
          begin
            hit         = 1'b1;
            off_fmt     = OFF_ITYPE;
            // unsigned forms and ld need no extension
            sign_extend = ~funct3[2] & (funct3[1:0] != 2'b11);
            inst_size   = ld_size_e'(funct3[1:0]);
            lsfifo      = 1'b1;
          end
        end
        LOAD_FP:
        begin
          if (funct3 == 3'b001 || funct3 == 3'b010 || funct3 == 3'b011)  // flh flw fld
          begin
            hit       = 1'b1;
            off_fmt   = OFF_ITYPE;
            inst_size = ld_size_e'(funct3[1:0]);
            fls       = 1'b1;
            lsfifo    = 1'b1;
          end
        end
        default:
        begin
          hit = 1'b0;
        end
      endcase
    end
    else if ((c_quad == C_QUAD0 || c_quad == C_QUAD2) &&
             !c_funct3[2] && c_funct3[1:0] != 2'b00)
    begin
      // c.fld c.lw c.ld and their sp forms
      hit         = 1'b1;
      sign_extend = (c_funct3 == 3'b010);
      inst_size   = (c_funct3[1:0] == 2'b10) ? WORD : DWORD;
      fls         = (c_funct3 == 3'b001);
      lsfifo      = (c_quad == C_QUAD0);    // sp forms skip the fifo
      if (c_quad == C_QUAD0)
      begin
        off_fmt = (c_funct3 == 3'b010) ? OFF_CL_W : OFF_CL_D;
      end
      else
      begin
        off_fmt = (c_funct3 == 3'b010) ? OFF_CI_W : OFF_CI_D;
      end
    end
  end

endmodule

// File: logic/ld_decd_if.sv
//====================================================================
// decoded load passed from the decode stage to the offset stage
//====================================================================
`timescale 1ns/1ps

interface ld_decd_if import rv_inst_pkg::*, ld_decd_pkg::*; ();

  logic              vld;
  logic              illegal;        // neither decoder matched
  logic [INST_W-1:0] inst;           // kept for offset and shift fields
  off_fmt_e          off_fmt;
  logic              atomic;
  logic              sign_extend;
  ld_type_e          inst_type;
  ld_size_e          inst_size;
  logic              fls;            // float destination
  logic              off_0_extend;
  logic              lsfifo;

  modport producer (
    output vld, illegal, inst, off_fmt, atomic, sign_extend,
           inst_type, inst_size, fls, off_0_extend, lsfifo
  );

  modport consumer (
    input  vld, illegal, inst, off_fmt, atomic, sign_extend,
           inst_type, inst_size, fls, off_0_extend, lsfifo
  );

endinterface

// File: logic/ld_decd_pkg.sv
//====================================================================
// load decode field types
// access size, reservation type and offset format of a decoded load
//====================================================================
package ld_decd_pkg;

  localparam int OFFSET_W      = 12;
  localparam int OFFSET_PLUS_W = 13;
  localparam int SHIFT_W       = 4;
  localparam int OFFSET_INC    = 16;   // added to the offset for the upper access

  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HALF  = 2'b01,
    WORD  = 2'b10,
    DWORD = 2'b11
  } ld_size_e;

  typedef enum logic [1:0] {
    NORMAL  = 2'b00,
    RESERVE = 2'b01    // lr, sets the reservation
  } ld_type_e;

  // which offset the second stage assembles
  typedef enum logic [2:0] {
    OFF_ZERO  = 3'd0,  // atomics and undecoded words
    OFF_ITYPE = 3'd1,
    OFF_CL_W  = 3'd2,
    OFF_CL_D  = 3'd3,
    OFF_CI_W  = 3'd4,
    OFF_CI_D  = 3'd5,
    OFF_INDEX = 3'd6   // register indexed, shift from bits 26:25
  } off_fmt_e;

endpackage

// File: logic/rv_inst_pkg.sv
//====================================================================
// rv instruction word encodings
// major opcodes, compressed quadrants and load-related funct fields
//====================================================================
package rv_inst_pkg;

  localparam int INST_W   = 32;
  localparam int FUNCT3_W = 3;

  // bits 6:0 of a 32-bit word
  typedef enum logic [6:0] {
    LOAD    = 7'b0000011,
    LOAD_FP = 7'b0000111,
    CUSTOM0 = 7'b0001011,   // vendor indexed loads
    AMO     = 7'b0101111
  } rv_major_e;

  // compressed quadrants in bits 1:0
  localparam logic [1:0] C_QUAD0 = 2'b00;
  localparam logic [1:0] C_QUAD2 = 2'b10;   // stack pointer relative

  // funct3 of the atomic and indexed groups
  localparam logic [FUNCT3_W-1:0] F3_AMO_W   = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_AMO_D   = 3'b011;
  localparam logic [FUNCT3_W-1:0] F3_IDX_INT = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_IDX_FP  = 3'b110;

  localparam logic [4:0] FUNCT5_LR = 5'b00010;   // lr.w and lr.d

endpackage
